//--- bench/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int PERIOD = 10
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

//--- bench/tb_control_unit.sv
`include "cpu_ctrl_defines.svh"

module tb_control_unit;

    localparam int N_INSTR = 60;
    localparam int CLK_PERIOD = 10;
    // Fetch0, fetch1 and decode
    localparam int FETCH_LEN = `MEM_WAIT_CYCLES + 2;
    localparam int MAX_INSTR_CYCLES = FETCH_LEN + 2 + `EXC_WAIT_CYCLES + 1;
    localparam int TIMEOUT = N_INSTR * MAX_INSTR_CYCLES * CLK_PERIOD + 2 * CLK_PERIOD + 500;

    localparam logic [1:0] KIND_OK      = 2'd0;
    localparam logic [1:0] KIND_OVF     = 2'd1;
    localparam logic [1:0] KIND_UNKNOWN = 2'd2;

    logic                 clk;
    logic                 reset = 1'b1;
    logic [`OPCODE_W-1:0] opcode = '0;
    logic [`FUNCT_W-1:0]  funct = '0;
    logic                 ov = 1'b0;

    logic       pc_write;
    logic       mem_wr;
    logic       ir_write;
    logic       a_write;
    logic       b_write;
    logic       alu_reg_write;
    logic       epc_write;
    logic       reg_write;
    logic [1:0] reg_dst;
    logic [1:0] except_cause;
    logic [1:0] alu_src_a;
    logic [2:0] iord;
    logic [2:0] alu_src_b;
    logic [2:0] alu_op;
    logic [2:0] pc_src;

    integer      seed = 32'h2e2e;
    int          phase = 0;
    int          instr_count = 0;
    int          predicted_exc = 0;
    int          epc_count = 0;
    logic        supported;
    logic [1:0]  kind;
    logic [25:0] dut_word;
    logic [25:0] exp_word;

    tb_clock_gen #(.PERIOD(CLK_PERIOD)) clock_gen_inst (.clk(clk));

    control_unit control_unit_inst (
        .clk           (clk),
        .reset         (reset),
        .opcode        (opcode),
        .funct         (funct),
        .ov            (ov),
        .pc_write      (pc_write),
        .mem_wr        (mem_wr),
        .ir_write      (ir_write),
        .a_write       (a_write),
        .b_write       (b_write),
        .alu_reg_write (alu_reg_write),
        .epc_write     (epc_write),
        .reg_write     (reg_write),
        .reg_dst       (reg_dst),
        .except_cause  (except_cause),
        .alu_src_a     (alu_src_a),
        .iord          (iord),
        .alu_src_b     (alu_src_b),
        .alu_op        (alu_op),
        .pc_src        (pc_src)
    );

    task automatic report_error(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        $display("Something failed");
        $fatal(1);
    endtask

    function automatic logic is_supported(input logic [5:0] op, input logic [5:0] fn);
        return (op == `R_OPCODE) &&
               (fn == `FUNCT_ADD || fn == `FUNCT_SUB || fn == `FUNCT_AND);
    endfunction

    function automatic int last_phase(input logic [1:0] k);
        if (k == KIND_OK) begin
            return FETCH_LEN + 2;
        end else if (k == KIND_OVF) begin
            return FETCH_LEN + 2 + `EXC_WAIT_CYCLES;
        end else begin
            return FETCH_LEN + `EXC_WAIT_CYCLES;
        end
    endfunction

    // Output pattern for a cycle counted from fetch0 entry
    function automatic logic [25:0] expected_word(input int ph, input logic [1:0] k,
                                                  input logic [5:0] fn);
        logic       pcw, mw, irw, aw, bw, arw, epw, rw;
        logic [1:0] rd, ec, asa;
        logic [2:0] io, asb, aop, psrc;
        int         exc_start;
        {pcw, mw, irw, aw, bw, arw, epw, rw} = 8'h00;
        {rd, ec, asa} = 6'b0;
        {io, asb, aop, psrc} = 12'b0;
        exc_start = (k == KIND_UNKNOWN) ? FETCH_LEN : FETCH_LEN + 2;
        if (ph < `MEM_WAIT_CYCLES) begin
            asb = 3'b001;
            aop = 3'b001;
        end else if (ph < FETCH_LEN) begin
            pcw = 1'b1;
            irw = 1'b1;
            mw  = 1'b1;
            io  = 3'b001;
            asb = 3'b001;
            aop = 3'b001;
            if (ph == FETCH_LEN - 1) begin
                aw  = 1'b1;
                bw  = 1'b1;
                asb = 3'b011;
            end
        end else if (k != KIND_UNKNOWN && ph == FETCH_LEN) begin
            asa = 2'b01;
            arw = 1'b1;
            if (fn == `FUNCT_ADD) begin
                aop = 3'b001;
            end else if (fn == `FUNCT_SUB) begin
                aop = 3'b011;
            end else begin
                aop = 3'b010;
            end
        end else if (k == KIND_OK && ph == FETCH_LEN + 2) begin
            rw = 1'b1;
            rd = 2'b01;
        end else if (k != KIND_OK && ph >= exc_start && ph < exc_start + `EXC_WAIT_CYCLES) begin
            ec  = (k == KIND_OVF) ? 2'b01 : 2'b00;
            io  = 3'b010;
            asb = 3'b001;
            aop = 3'b010;
        end else if (k != KIND_OK && ph == exc_start + `EXC_WAIT_CYCLES) begin
            epw  = 1'b1;
            pcw  = 1'b1;
            psrc = 3'b011;
        end
        return {pcw, mw, irw, aw, bw, arw, epw, rw, rd, ec, asa, io, asb, aop, psrc};
    endfunction

    // First five are directed, the rest random
    task automatic drive_instruction(input int idx);
        logic [31:0] r;
        logic [5:0]  op;
        logic [5:0]  fn;
        logic        new_ov;
        r = $random(seed);
        op = `R_OPCODE;
        fn = `FUNCT_ADD;
        new_ov = 1'b0;
        case (idx)
            0: fn = `FUNCT_ADD;
            1: fn = `FUNCT_SUB;
            2: fn = `FUNCT_AND;
            3: new_ov = 1'b1;
            4: begin
                op = r[5:0] | 6'h01;
                fn = r[11:6];
            end
            default: begin
                new_ov = (r[9:8] == 2'b00);
                case (r[2:0])
                    3'd0, 3'd1: fn = `FUNCT_ADD;
                    3'd2, 3'd4: fn = `FUNCT_SUB;
                    3'd3, 3'd5: fn = `FUNCT_AND;
                    3'd6: fn = r[15:10];
                    default: begin
                        op = r[21:16] | 6'h01;
                        fn = r[15:10];
                    end
                endcase
            end
        endcase
        opcode <= op;
        funct  <= fn;
        ov     <= new_ov;
    endtask

    assign supported = is_supported(opcode, funct);
    assign kind = !supported ? KIND_UNKNOWN : (ov ? KIND_OVF : KIND_OK);
    assign exp_word = expected_word(phase, kind, funct);
    assign dut_word = {pc_write, mem_wr, ir_write, a_write, b_write, alu_reg_write,
                       epc_write, reg_write, reg_dst, except_cause, alu_src_a,
                       iord, alu_src_b, alu_op, pc_src};

    // Reference model and stimulus
    always @(posedge clk) begin
        if (reset) begin
            phase <= 0;
            drive_instruction(0);
        end else if (phase == last_phase(kind)) begin
            phase <= 0;
            instr_count <= instr_count + 1;
            if (kind != KIND_OK) begin
                predicted_exc <= predicted_exc + 1;
            end
            drive_instruction(instr_count + 1);
        end else begin
            phase <= phase + 1;
        end
    end

    always @(negedge clk) begin
        if (!reset && epc_write) begin
            epc_count <= epc_count + 1;
        end
    end

    a_outputs_match: assert property (@(posedge clk) disable iff (reset)
        dut_word == exp_word)
        else report_error($sformatf("outputs %h, expected %h in cycle %0d of instruction %0d",
                                    $sampled(dut_word), $sampled(exp_word),
                                    $sampled(phase), $sampled(instr_count)));

    a_no_wb_on_exc: assert property (@(posedge clk) disable iff (reset)
        !(reg_write && epc_write))
        else report_error("reg_write and epc_write high in the same cycle");

    a_reg_write_pulse: assert property (@(posedge clk) disable iff (reset)
        reg_write |=> !reg_write)
        else report_error("reg_write held for more than one cycle");

    a_fetch_after_exc: assert property (@(posedge clk) disable iff (reset)
        epc_write |=> (alu_src_b == 3'b001 && alu_op == 3'b001 && !pc_write))
        else report_error("no fetch0 pattern after exception entry");

    initial begin
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        wait (instr_count == N_INSTR);
        @(negedge clk);
        if (epc_count != predicted_exc) begin
            report_error($sformatf("%0d epc_write pulses, expected %0d",
                                   epc_count, predicted_exc));
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

    // Watchdog
    initial begin
        #(TIMEOUT);
        $display("The run timed out before all %0d instructions completed", N_INSTR);
        $display("Something failed");
        $fatal(1);
    end

endmodule

//--- flist.f
+incdir+include
verilog/cpu_ctrl_pkg.sv
verilog/ctrl_word_if.sv
verilog/instr_decoder.sv
verilog/main_fsm.sv
verilog/control_encoder.sv
verilog/control_unit.sv
bench/tb_clock_gen.sv
bench/tb_control_unit.sv

//--- include/cpu_ctrl_defines.svh
`ifndef CPU_CTRL_DEFINES_SVH
`define CPU_CTRL_DEFINES_SVH

// Instruction field widths
`define OPCODE_W 6
`define FUNCT_W 6

// R-type opcode
`define R_OPCODE 6'h00

// Supported R-type funct codes
`define FUNCT_ADD 6'h20
`define FUNCT_SUB 6'h22
`define FUNCT_AND 6'h24

// Cycles that fetch0 is held while memory answers
`define MEM_WAIT_CYCLES 3

// Cycles an exception is held while the vector is read
`define EXC_WAIT_CYCLES 4

// Wait counter width, wide enough for both lengths
`define WAIT_CNT_W 3

`endif

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timing -f flist.f --top-module tb_control_unit \
    -o tb_control_unit \
    && ./obj_dir/tb_control_unit | tee /dev/stderr | grep -q "Everything OK" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- verilog/control_encoder.sv
module control_encoder
    import cpu_ctrl_pkg::*;
(
    input  fsm_state_e   state,
    input  instr_class_e alu_class,
    input  exc_cause_e   cause,
    ctrl_word_if.source  ctrl
);

    always_comb begin
        ctrl.pc_write      = 1'b0;
        ctrl.mem_wr        = 1'b0;
        ctrl.ir_write      = 1'b0;
        ctrl.a_write       = 1'b0;
        ctrl.b_write       = 1'b0;
        ctrl.alu_reg_write = 1'b0;
        ctrl.epc_write     = 1'b0;
        ctrl.reg_write     = 1'b0;
        ctrl.reg_dst       = 2'b00;
        ctrl.except_cause  = exc_no_opcode;
        ctrl.alu_src_a     = 2'b00;
        ctrl.iord          = 3'b000;
        ctrl.alu_src_b     = 3'b000;
        ctrl.alu_op        = alu_none;
        ctrl.pc_src        = 3'b000;

        case (state)
            st_fetch0: begin
                // PC + 4 computed while memory answers
                ctrl.alu_src_b = 3'b001;
                ctrl.alu_op    = alu_pass_add;
            end
            st_fetch1: begin
                ctrl.pc_write  = 1'b1;
                ctrl.ir_write  = 1'b1;
                ctrl.mem_wr    = 1'b1;
                ctrl.iord      = 3'b001;
                ctrl.alu_src_b = 3'b001;
                ctrl.alu_op    = alu_pass_add;
            end
            st_decode: begin
                ctrl.pc_write  = 1'b1;
                ctrl.ir_write  = 1'b1;
                ctrl.mem_wr    = 1'b1;
                ctrl.iord      = 3'b001;
                ctrl.a_write   = 1'b1;
                ctrl.b_write   = 1'b1;
                // Branch target offset on B input
                ctrl.alu_src_b = 3'b011;
                ctrl.alu_op    = alu_pass_add;
            end
            st_execute: begin
                ctrl.alu_src_a     = 2'b01;
                ctrl.alu_src_b     = 3'b000;
                ctrl.alu_reg_write = 1'b1;
                case (alu_class)
                    class_add: begin
                        ctrl.alu_op = alu_pass_add;
                    end
                    class_and: begin
                        ctrl.alu_op = alu_and;
                    end
                    class_sub: begin
                        ctrl.alu_op = alu_sub;
                    end
                    default: begin
                        ctrl.alu_op = alu_none;
                    end
                endcase
            end
            st_overflow_check: begin
                // Idle while the ALU flags settle
                ctrl.alu_op = alu_none;
            end
            st_reg_write: begin
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst   = 2'b01;
            end
            st_exc_wait: begin
                ctrl.except_cause = cause;
                ctrl.iord         = 3'b010;
                ctrl.alu_src_b    = 3'b001;
                ctrl.alu_op       = alu_and;
            end
            st_exc_enter: begin
                ctrl.epc_write = 1'b1;
                ctrl.pc_write  = 1'b1;
                // Exception vector
                ctrl.pc_src    = 3'b011;
            end
            default: begin
                ctrl.alu_op = alu_none;
            end
        endcase
    end

endmodule

//--- verilog/control_unit.sv
`include "cpu_ctrl_defines.svh"

module control_unit
    import cpu_ctrl_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic [`OPCODE_W-1:0] opcode,
    input  logic [`FUNCT_W-1:0]  funct,
    input  logic                 ov,
    output logic                 pc_write,
    output logic                 mem_wr,
    output logic                 ir_write,
    output logic                 a_write,
    output logic                 b_write,
    output logic                 alu_reg_write,
    output logic                 epc_write,
    output logic                 reg_write,
    output logic [1:0]           reg_dst,
    output logic [1:0]           except_cause,
    output logic [1:0]           alu_src_a,
    output logic [2:0]           iord,
    output logic [2:0]           alu_src_b,
    output logic [2:0]           alu_op,
    output logic [2:0]           pc_src
);

    instr_class_e instr_class;
    fsm_state_e   state;
    instr_class_e alu_class;
    exc_cause_e   cause;

    ctrl_word_if ctrl_bus ();

    instr_decoder instr_decoder_inst (
        .opcode      (opcode),
        .funct       (funct),
        .instr_class (instr_class)
    );

    main_fsm main_fsm_inst (
        .clk         (clk),
        .reset       (reset),
        .instr_class (instr_class),
        .ov          (ov),
        .state       (state),
        .alu_class   (alu_class),
        .cause       (cause)
    );

    control_encoder control_encoder_inst (
        .state     (state),
        .alu_class (alu_class),
        .cause     (cause),
        .ctrl      (ctrl_bus.source)
    );

    // Break the control word out to plain ports
    assign pc_write      = ctrl_bus.pc_write;
    assign mem_wr        = ctrl_bus.mem_wr;
    assign ir_write      = ctrl_bus.ir_write;
    assign a_write       = ctrl_bus.a_write;
    assign b_write       = ctrl_bus.b_write;
    assign alu_reg_write = ctrl_bus.alu_reg_write;
    assign epc_write     = ctrl_bus.epc_write;
    assign reg_write     = ctrl_bus.reg_write;
    assign reg_dst       = ctrl_bus.reg_dst;
    assign except_cause  = ctrl_bus.except_cause;
    assign alu_src_a     = ctrl_bus.alu_src_a;
    assign iord          = ctrl_bus.iord;
    assign alu_src_b     = ctrl_bus.alu_src_b;
    assign alu_op        = ctrl_bus.alu_op;
    assign pc_src        = ctrl_bus.pc_src;

endmodule

//--- verilog/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

    // Control FSM states
    typedef enum logic [2:0] {
        st_fetch0         = 3'd0,
        st_fetch1         = 3'd1,
        st_decode         = 3'd2,
        st_execute        = 3'd3,
        st_overflow_check = 3'd4,
        st_reg_write      = 3'd5,
        st_exc_wait       = 3'd6,
        st_exc_enter      = 3'd7
    } fsm_state_e;

    // Decoded instruction class
    typedef enum logic [1:0] {
        class_add     = 2'd0,
        class_sub     = 2'd1,
        class_and     = 2'd2,
        class_unknown = 2'd3
    } instr_class_e;

    // ALU operation select, as seen by the datapath
    typedef enum logic [2:0] {
        alu_none     = 3'b000,
        alu_pass_add = 3'b001,
        alu_and      = 3'b010,
        alu_sub      = 3'b011
    } alu_op_e;

    // Exception cause written next to EPC
    typedef enum logic [1:0] {
        exc_no_opcode = 2'b00,
        exc_overflow  = 2'b01
    } exc_cause_e;

endpackage

//--- verilog/ctrl_word_if.sv
interface ctrl_word_if
    import cpu_ctrl_pkg::*;
();

    logic       pc_write;
    logic       mem_wr;
    logic       ir_write;
    logic       a_write;
    logic       b_write;
    logic       alu_reg_write;
    logic       epc_write;
    logic       reg_write;
    logic [1:0] reg_dst;
    exc_cause_e except_cause;
    logic [1:0] alu_src_a;
    logic [2:0] iord;
    logic [2:0] alu_src_b;
    alu_op_e    alu_op;
    logic [2:0] pc_src;

    modport source (
        output pc_write, mem_wr, ir_write, a_write, b_write, alu_reg_write,
        output epc_write, reg_write, reg_dst, except_cause, alu_src_a,
        output iord, alu_src_b, alu_op, pc_src
    );

    modport sink (
        input pc_write, mem_wr, ir_write, a_write, b_write, alu_reg_write,
        input epc_write, reg_write, reg_dst, except_cause, alu_src_a,
        input iord, alu_src_b, alu_op, pc_src
    );

endinterface

//--- verilog/instr_decoder.sv
`include "cpu_ctrl_defines.svh"

module instr_decoder
    import cpu_ctrl_pkg::*;
(
    input  logic [`OPCODE_W-1:0] opcode,
    input  logic [`FUNCT_W-1:0]  funct,
    output instr_class_e         instr_class
);

    always_comb begin
        instr_class = class_unknown;
        case (opcode)
            `R_OPCODE: begin
                // Only three R-type ops are sequenced
                case (funct)
                    `FUNCT_ADD: begin
                        instr_class = class_add;
                    end
                    `FUNCT_SUB: begin
                        instr_class = class_sub;
                    end
                    `FUNCT_AND: begin
                        instr_class = class_and;
                    end
                    default: begin
                        instr_class = class_unknown;
                    end
                endcase
            end
            // I-type and J-type fall through to the no-opcode exception
            default: begin
                instr_class = class_unknown;
            end
        endcase
    end

endmodule

//--- verilog/main_fsm.sv
`include "cpu_ctrl_defines.svh"

module main_fsm
    import cpu_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  instr_class_e instr_class,
    input  logic         ov,
    output fsm_state_e   state,
    output instr_class_e alu_class,
    output exc_cause_e   cause
);

    localparam logic [`WAIT_CNT_W-1:0] MEM_LAST = `WAIT_CNT_W'(`MEM_WAIT_CYCLES - 1);
    localparam logic [`WAIT_CNT_W-1:0] EXC_LAST = `WAIT_CNT_W'(`EXC_WAIT_CYCLES - 1);

    fsm_state_e            state_next;
    exc_cause_e            entry_cause;
    logic [`WAIT_CNT_W-1:0] wait_cnt;

    always_comb begin
        state_next  = state;
        entry_cause = exc_no_opcode;
        case (state)
            st_fetch0: begin
                if (wait_cnt == MEM_LAST) begin
                    state_next = st_fetch1;
                end
            end
            st_fetch1: begin
                state_next = st_decode;
            end
            st_decode: begin
                // Opcode and funct are valid at the end of decode
                if (instr_class == class_unknown) begin
                    state_next  = st_exc_wait;
                    entry_cause = exc_no_opcode;
                end else begin
                    state_next = st_execute;
                end
            end
            st_execute: begin
                state_next = st_overflow_check;
            end
            st_overflow_check: begin
                if (ov) begin
                    state_next  = st_exc_wait;
                    entry_cause = exc_overflow;
                end else begin
                    state_next = st_reg_write;
                end
            end
            st_reg_write: begin
                state_next = st_fetch0;
            end
            st_exc_wait: begin
                if (wait_cnt == EXC_LAST) begin
                    state_next = st_exc_enter;
                end
            end
            st_exc_enter: begin
                state_next = st_fetch0;
            end
            default: begin
                state_next = st_fetch0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= st_fetch0;
            wait_cnt <= '0;
        end else begin
            state <= state_next;
            // Counter only runs while a state is held
            if (state_next != state) begin
                wait_cnt <= '0;
            end else begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end
    end

    // Instruction class and exception cause
    always_ff @(posedge clk) begin
        if (state == st_decode) begin
            alu_class <= instr_class;
        end
        if (state_next == st_exc_wait && state != st_exc_wait) begin
            cause <= entry_cause;
        end
    end

    a_wait_cnt_bound: assert property (@(posedge clk) disable iff (reset)
        (state == st_fetch0)   ? (wait_cnt < `WAIT_CNT_W'(`MEM_WAIT_CYCLES)) :
        (state == st_exc_wait) ? (wait_cnt < `WAIT_CNT_W'(`EXC_WAIT_CYCLES)) :
                                 (wait_cnt == '0))
        else $error("wait counter out of range in state %s", state.name());

endmodule
